// File: logic/core_pkg.sv
/*
 * Control block shared definitions
 * Wishbone request/response structs, slave address map,
 * setting register numbers, reset values and readback layout
 */
package core_pkg;

   // Bus geometry
   localparam int BUS_DW   = 32;   // Data width
   localparam int BUS_AW   = 16;   // Byte address width
   localparam int BUS_SW   = 4;    // Byte selects
   localparam int DECODE_W = 8;    // Upper address bits used by the decoder

   typedef struct packed {
      logic [BUS_AW-1:0] adr;
      logic [BUS_DW-1:0] dat;
      logic [BUS_SW-1:0] sel;
      logic              we;
      logic              stb;
      logic              cyc;
   } wb_req_t;

   typedef struct packed {
      logic [BUS_DW-1:0] dat;
      logic              ack;
   } wb_rsp_t;

   ////////////////////////////////////////////////////////////
   // Address map compared against adr[15:8] under the mask
   localparam logic [DECODE_W-1:0] MAIN_RAM_BASE = 8'h00;   // 0x0000-0x3FFF
   localparam logic [DECODE_W-1:0] MAIN_RAM_MASK = 8'hC0;
   localparam logic [DECODE_W-1:0] READBACK_BASE = 8'h5C;   // 0x5C00-0x5FFF
   localparam logic [DECODE_W-1:0] READBACK_MASK = 8'hFC;
   localparam logic [DECODE_W-1:0] SETTINGS_BASE = 8'h70;   // 0x7000-0x7FFF
   localparam logic [DECODE_W-1:0] SETTINGS_MASK = 8'hF0;
   localparam logic [DECODE_W-1:0] BOOT_RAM_BASE = 8'hC0;   // 0xC000-0xFFFF
   localparam logic [DECODE_W-1:0] BOOT_RAM_MASK = 8'hC0;

   localparam logic [BUS_AW-1:0] BOOT_SWAP_MASK = 16'hC000;
   localparam int RAM_AW = 10;   // 1K words per RAM

   // One-hot slave strobes
   typedef logic [3:0] slave_sel_t;
   localparam int SLV_MAIN     = 0;
   localparam int SLV_READBACK = 1;
   localparam int SLV_SETTINGS = 2;
   localparam int SLV_BOOT     = 3;

   ////////////////////////////////////////////////////////////
   // Settings bus
   localparam int SET_AW       = 8;
   localparam int SR_MISC      = 0;
   localparam int SR_DIVSW     = 180;   // Two registers
   localparam int SR_CLK_OUTS  = 0;
   localparam int SR_LEDS_SW   = 3;
   localparam int SR_PHY_RESET = 4;
   localparam int SR_BLDR_DONE = 5;
   localparam int SR_LED_SRC   = 6;

   localparam logic [7:0]  LED_SRC_RESET = 8'b0001_1110;
   localparam logic        DIVSW_RESET   = 1'b1;
   localparam logic [31:0] COMPAT_NUM    = 32'h0008_0002;   // Major 8, minor 2

   // Readback word indices
   localparam logic [3:0] RB_ADC_WORD    = 4'd6;
   localparam logic [3:0] RB_COMPAT_WORD = 4'd12;
   localparam logic [3:0] RB_STATUS_WORD = 4'd13;

endpackage

// File: logic/boot_control.sv
/*
 * Boot reset controller
 * Holds the bus in reset during power-on, swaps boot and main RAM
 * until the bootloader is done, then pulses a one-cycle bus reset
 */
`timescale 1ns/1ps

module boot_control (
   input  logic                         wb_clk,
   input  logic                         por_rst,
   input  logic                         bldr_done_i,
   input  logic [core_pkg::BUS_AW-1:0]  cpu_adr_i,
   output logic                         wb_rst_o,
   output logic [core_pkg::BUS_AW-1:0]  bus_adr_o
);
   import core_pkg::*;

   typedef enum logic {
      WAIT,
      DONE
   } boot_state_t;

   boot_state_t state;
   logic        swap;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state    <= WAIT;
         wb_rst_o <= 1'b1;
      end else begin
         case (state)
            WAIT: begin
               wb_rst_o <= 1'b0;
               if (bldr_done_i) begin   // Handover from bootloader
                  state    <= DONE;
                  wb_rst_o <= 1'b1;
               end
            end
            DONE: wb_rst_o <= 1'b0;     // Stays here until next POR
            default: state <= WAIT;
         endcase
      end
   end

   // Only the 00 and 11 quadrants trade places
   assign swap      = (state == WAIT) && (cpu_adr_i[15] == cpu_adr_i[14]);
   assign bus_adr_o = swap ? (cpu_adr_i ^ BOOT_SWAP_MASK) : cpu_adr_i;

endmodule

// File: logic/wb_decoder.sv
/*
 * Wishbone address decoder
 * Turns the upper address byte into one-hot slave strobes and
 * merges the slave responses back to the master
 */
`timescale 1ns/1ps

module wb_decoder (
   input  core_pkg::wb_req_t    req_i,
   output core_pkg::slave_sel_t sel_o,
   input  core_pkg::wb_rsp_t    main_rsp_i,
   input  core_pkg::wb_rsp_t    readback_rsp_i,
   input  core_pkg::wb_rsp_t    settings_rsp_i,
   input  core_pkg::wb_rsp_t    boot_rsp_i,
   output core_pkg::wb_rsp_t    rsp_o
);
   import core_pkg::*;

   logic [DECODE_W-1:0] dec_adr;
   logic                bus_active;
   logic                main_hit;
   logic                readback_hit;
   logic                settings_hit;
   logic                boot_hit;
   logic                ram_hit;

   function automatic logic window_hit(
      input logic [DECODE_W-1:0] adr,
      input logic [DECODE_W-1:0] base,
      input logic [DECODE_W-1:0] mask
   );
      window_hit = ((adr ^ base) & mask) == '0;
   endfunction

   assign dec_adr    = req_i.adr[BUS_AW-1 -: DECODE_W];
   assign bus_active = req_i.cyc & req_i.stb;

   assign main_hit     = window_hit(dec_adr, MAIN_RAM_BASE, MAIN_RAM_MASK);
   assign readback_hit = window_hit(dec_adr, READBACK_BASE, READBACK_MASK);
   assign settings_hit = window_hit(dec_adr, SETTINGS_BASE, SETTINGS_MASK);
   assign boot_hit     = window_hit(dec_adr, BOOT_RAM_BASE, BOOT_RAM_MASK);
   assign ram_hit      = main_hit | boot_hit;   // RAM windows win any overlap

   ////////////////////////////////////////////////////////////
   // Slave strobes
   assign sel_o[SLV_MAIN]     = bus_active & main_hit;
   assign sel_o[SLV_BOOT]     = bus_active & boot_hit;
   assign sel_o[SLV_READBACK] = bus_active & readback_hit & ~ram_hit;
   assign sel_o[SLV_SETTINGS] = bus_active & settings_hit & ~ram_hit;

   ////////////////////////////////////////////////////////////
   // Idle slaves drive zeros so the responses simply OR together
   assign rsp_o.dat = main_rsp_i.dat | readback_rsp_i.dat
                    | settings_rsp_i.dat | boot_rsp_i.dat;
   assign rsp_o.ack = main_rsp_i.ack | readback_rsp_i.ack
                    | settings_rsp_i.ack | boot_rsp_i.ack;

endmodule

// File: logic/wb_ram.sv
/*
 * Single-port Wishbone word RAM
 * Byte-lane writes, registered reads, one-cycle acknowledge
 */
`timescale 1ns/1ps

module wb_ram (
   input  logic              wb_clk,
   input  logic              wb_rst_i,
   input  core_pkg::wb_req_t req_i,
   input  logic              stb_i,
   output core_pkg::wb_rsp_t rsp_o
);
   import core_pkg::*;

   logic [BUS_DW-1:0] mem [0:(2**RAM_AW)-1];
   logic [RAM_AW-1:0] word_adr;
   logic [BUS_DW-1:0] rd_dat;
   logic              ack_q;
   logic              access;

   assign word_adr = req_i.adr[RAM_AW+1:2];   // Aliases within the window
   assign access   = stb_i & ~ack_q;

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Contents survive bus reset
   always_ff @(posedge wb_clk) begin
      if (access) begin
         rd_dat <= mem[word_adr];
         if (req_i.we) begin
            for (int b = 0; b < BUS_SW; b++) begin
               if (req_i.sel[b]) begin
                  mem[word_adr][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = ack_q ? rd_dat : '0;

endmodule

// File: logic/misc_settings.sv
/*
 * Settings bus and miscellaneous setting registers
 * Bus writes become register strobes; holds clock outputs, PHY reset,
 * bootloader done, LEDs, LED source and diversity switches
 */
`timescale 1ns/1ps

module misc_settings (
   input  logic              wb_clk,
   input  logic              wb_rst_i,
   input  core_pkg::wb_req_t req_i,
   input  logic              stb_i,
   output core_pkg::wb_rsp_t rsp_o,
   input  logic [3:0]        run_i,
   output logic [7:0]        leds_o,
   output logic [1:0]        lms_res_o,
   output logic              phy_resetn_o,
   output logic [1:0]        div_sw_o,
   output logic              bldr_done_o
);
   import core_pkg::*;

   logic              ack_q;
   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [BUS_DW-1:0] set_data;

   logic [1:0] lms_res_q;    // Bits 6:5 of the clock outputs
   logic [7:0] led_sw_q;
   logic [7:0] led_src_q;    // 1 = hardware, 0 = software
   logic [7:0] led_hw;
   logic       phy_reset_q;
   logic       bldr_done_q;
   logic [1:0] div_sw_q;

   ////////////////////////////////////////////////////////////
   // Bus side
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= stb_i & ~ack_q;
      end
   end

   assign set_stb   = ack_q & req_i.we;             // Coincides with write ack
   assign set_addr  = req_i.adr[SET_AW+1:2];        // Word number mod 256
   assign set_data  = req_i.dat;
   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = '0;                           // Write-only window

   ////////////////////////////////////////////////////////////
   // Registers
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         lms_res_q   <= '0;
         led_sw_q    <= '0;
         led_src_q   <= LED_SRC_RESET;
         phy_reset_q <= 1'b0;
         bldr_done_q <= 1'b0;
         div_sw_q    <= {2{DIVSW_RESET}};
      end else if (set_stb) begin
         case (set_addr)
            SET_AW'(SR_MISC + SR_CLK_OUTS):  lms_res_q   <= set_data[6:5];
            SET_AW'(SR_MISC + SR_LEDS_SW):   led_sw_q    <= set_data[7:0];
            SET_AW'(SR_MISC + SR_PHY_RESET): phy_reset_q <= set_data[0];
            SET_AW'(SR_MISC + SR_BLDR_DONE): bldr_done_q <= set_data[0];
            SET_AW'(SR_MISC + SR_LED_SRC):   led_src_q   <= set_data[7:0];
            SET_AW'(SR_DIVSW):               div_sw_q[0] <= set_data[0];
            SET_AW'(SR_DIVSW + 1):           div_sw_q[1] <= set_data[0];
            default: ;                       // Not ours
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Outputs and LED mux
   assign led_hw = {3'b000, run_i, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   assign lms_res_o    = lms_res_q;
   assign phy_resetn_o = ~phy_reset_q;
   assign div_sw_o     = div_sw_q;
   assign bldr_done_o  = bldr_done_q;

endmodule

// File: logic/readback_mux.sv
/*
 * Readback status window
 * Sixteen read-only words selected by adr[5:2], one-cycle acknowledge
 */
`timescale 1ns/1ps

module readback_mux (
   input  logic              wb_clk,
   input  logic              wb_rst_i,
   input  core_pkg::wb_req_t req_i,
   input  logic              stb_i,
   output core_pkg::wb_rsp_t rsp_o,
   input  logic [11:0]       adc_i_i,
   input  logic [11:0]       adc_q_i,
   input  logic              button_i,
   input  logic [1:0]        aux_ld_i
);
   import core_pkg::*;

   logic [BUS_DW-1:0] word_sel;
   logic [BUS_DW-1:0] rd_dat;
   logic              ack_q;

   always_comb begin
      case (req_i.adr[5:2])
         RB_ADC_WORD:    word_sel = {adc_i_i, 4'b0, adc_q_i, 4'b0};
         RB_COMPAT_WORD: word_sel = COMPAT_NUM;
         RB_STATUS_WORD: word_sel = {16'b0, aux_ld_i[1], aux_ld_i[0], button_i, 13'b0};
         default:        word_sel = '0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= stb_i & ~ack_q;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (stb_i & ~ack_q) begin
         rd_dat <= word_sel;   // Sampled with the request
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = ack_q ? rd_dat : '0;

endmodule

// File: logic/radio_core.sv
/*
 * Radio core system control
 * Wishbone-attached control block: boot controller, decoder,
 * main and boot RAM, settings registers and readback window
 */
`timescale 1ns/1ps

module radio_core (
   input  logic              wb_clk,
   input  logic              por_rst,
   input  core_pkg::wb_req_t wb_req_i,
   output core_pkg::wb_rsp_t wb_rsp_o,
   input  logic [11:0]       adc_i_i,
   input  logic [11:0]       adc_q_i,
   input  logic [3:0]        run_i,
   input  logic              button_i,
   input  logic [1:0]        aux_ld_i,
   output logic [7:0]        leds_o,
   output logic [1:0]        lms_res_o,
   output logic              phy_resetn_o,
   output logic [1:0]        div_sw_o
);
   import core_pkg::*;

   logic              wb_rst;
   logic              bldr_done;
   logic [BUS_AW-1:0] bus_adr;
   wb_req_t           bus_req;
   slave_sel_t        slave_sel;
   wb_rsp_t           main_rsp;
   wb_rsp_t           boot_rsp;
   wb_rsp_t           readback_rsp;
   wb_rsp_t           settings_rsp;

   ////////////////////////////////////////////////////////////
   // Boot control and address swap
   boot_control boot_control_inst (
      .wb_clk      (wb_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .cpu_adr_i   (wb_req_i.adr),
      .wb_rst_o    (wb_rst),
      .bus_adr_o   (bus_adr)
   );

   assign bus_req = '{adr: bus_adr, dat: wb_req_i.dat, sel: wb_req_i.sel,
                      we: wb_req_i.we, stb: wb_req_i.stb, cyc: wb_req_i.cyc};

   wb_decoder wb_decoder_inst (
      .req_i          (bus_req),
      .sel_o          (slave_sel),
      .main_rsp_i     (main_rsp),
      .readback_rsp_i (readback_rsp),
      .settings_rsp_i (settings_rsp),
      .boot_rsp_i     (boot_rsp),
      .rsp_o          (wb_rsp_o)
   );

   ////////////////////////////////////////////////////////////
   // Slaves
   wb_ram main_ram (
      .wb_clk   (wb_clk),
      .wb_rst_i (wb_rst),
      .req_i    (bus_req),
      .stb_i    (slave_sel[SLV_MAIN]),
      .rsp_o    (main_rsp)
   );

   wb_ram boot_ram (
      .wb_clk   (wb_clk),
      .wb_rst_i (wb_rst),
      .req_i    (bus_req),
      .stb_i    (slave_sel[SLV_BOOT]),
      .rsp_o    (boot_rsp)
   );

   misc_settings misc_settings_inst (
      .wb_clk       (wb_clk),
      .wb_rst_i     (wb_rst),
      .req_i        (bus_req),
      .stb_i        (slave_sel[SLV_SETTINGS]),
      .rsp_o        (settings_rsp),
      .run_i        (run_i),
      .leds_o       (leds_o),
      .lms_res_o    (lms_res_o),
      .phy_resetn_o (phy_resetn_o),
      .div_sw_o     (div_sw_o),
      .bldr_done_o  (bldr_done)
   );

   readback_mux readback_mux_inst (
      .wb_clk   (wb_clk),
      .wb_rst_i (wb_rst),
      .req_i    (bus_req),
      .stb_i    (slave_sel[SLV_READBACK]),
      .rsp_o    (readback_rsp),
      .adc_i_i  (adc_i_i),
      .adc_q_i  (adc_q_i),
      .button_i (button_i),
      .aux_ld_i (aux_ld_i)
   );

endmodule

// File: tests/wb_master_tasks.svh
/*
 * Wishbone master tasks
 * Single-beat write and read, each with a bounded wait for acknowledge
 */
`ifndef WB_MASTER_TASKS_SVH
`define WB_MASTER_TASKS_SVH

// One classic cycle with the request held until acknowledge
task automatic bus_cycle(input logic [15:0] address, input logic [31:0] wdata,
                         input logic [3:0] bsel, input logic write_en,
                         output logic [31:0] rdata, output logic acked);
   int waited;
   waited = 0;
   acked  = 1'b0;
   rdata  = '0;
   @(posedge wb_clk);
   wb_req <= '{adr: address, dat: wdata, sel: bsel, we: write_en, stb: 1'b1, cyc: 1'b1};
   while (!acked && waited < ACK_TIMEOUT) begin
      @(negedge wb_clk);   // Ack stable mid-cycle
      waited++;
      if (wb_rsp.ack) begin
         acked = 1'b1;
         rdata = wb_rsp.dat;
      end
   end
   @(posedge wb_clk);
   wb_req <= '0;          // Strobe drops after ack
   if (!acked) begin
      $display("Bus %s at address 0x%h was not acknowledged within %0d cycles",
               write_en ? "write" : "read", address, ACK_TIMEOUT);
      timeout_count++;
   end
endtask

task automatic wb_write(input logic [15:0] address, input logic [31:0] wdata,
                        input logic [3:0] bsel);
   logic [31:0] rd_discard;
   logic        acked;
   bus_cycle(address, wdata, bsel, 1'b1, rd_discard, acked);
endtask

task automatic wb_read(input logic [15:0] address, output logic [31:0] rdata,
                       output logic acked);
   bus_cycle(address, 32'h0, 4'hF, 1'b0, rdata, acked);
endtask

`endif

// File: tests/tb_radio_core.sv
/*
 * Testbench for the radio core control block
 * Applies a table of bus writes, read checks, input changes and port checks
 */
`timescale 1ns/1ps

module tb_radio_core;
   import core_pkg::*;

   localparam int ACK_TIMEOUT = 20;

   typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_INPUTS, OP_PORTS, OP_IDLE} op_kind_t;

   typedef struct packed {
      op_kind_t    kind;
      logic [15:0] adr;
      logic [31:0] dat;        // Write data, packed inputs or idle cycles
      logic [3:0]  sel;
      logic [31:0] expected;   // Read data or packed port values
   } op_row_t;

   logic        wb_clk = 1'b0;
   logic        por_rst;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic [11:0] adc_i;
   logic [11:0] adc_q;
   logic [3:0]  run;
   logic        button;
   logic [1:0]  aux_ld;
   logic [7:0]  leds;
   logic [1:0]  lms_res;
   logic        phy_resetn;
   logic [1:0]  div_sw;
   op_row_t     op_table[$];
   int          check_count;
   int          mismatch_count;
   int          timeout_count;

   `include "wb_master_tasks.svh"

   radio_core radio_core_inst (
      .wb_clk       (wb_clk),
      .por_rst      (por_rst),
      .wb_req_i     (wb_req),
      .wb_rsp_o     (wb_rsp),
      .adc_i_i      (adc_i),
      .adc_q_i      (adc_q),
      .run_i        (run),
      .button_i     (button),
      .aux_ld_i     (aux_ld),
      .leds_o       (leds),
      .lms_res_o    (lms_res),
      .phy_resetn_o (phy_resetn),
      .div_sw_o     (div_sw)
   );

   always #5 wb_clk = ~wb_clk;

   function automatic logic [15:0] set_adr(int num);
      return 16'h7000 + 16'(num * 4);
   endfunction

   function automatic logic [15:0] rb_adr(int word);
      return 16'h5C00 + 16'(word * 4);
   endfunction

   function automatic logic [31:0] port_word(logic [7:0] l, logic [1:0] m, logic p,
                                             logic [1:0] d);
      return {19'b0, l, m, p, d};
   endfunction

   task automatic add_row(input op_kind_t op_kind, input logic [15:0] address,
                          input logic [31:0] wdata, input logic [3:0] bsel,
                          input logic [31:0] exp_val);
      op_row_t row;
      row = '{kind: op_kind, adr: address, dat: wdata, sel: bsel, expected: exp_val};
      op_table.push_back(row);
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus table
   task automatic build_table();
      logic [31:0] word_a, word_b, word_c, word_d, merged;
      logic [31:0] clk_outs, phy_rst, div0, div1;
      logic [7:0]  led_sw, led_src, led_exp, led_hw_r;
      logic [31:0] status_exp;
      logic [11:0] adc_i_r, adc_q_r;
      logic [3:0]  run_r;
      logic        btn_r;
      logic [1:0]  aux_r;
      add_row(OP_PORTS, '0, '0, '0, port_word(8'h00, 2'b00, 1'b1, 2'b11));
      add_row(OP_WRITE, set_adr(SR_MISC + SR_LEDS_SW), 32'hFF, 4'hF, '0);
      add_row(OP_PORTS, '0, '0, '0, port_word(8'hE1, 2'b00, 1'b1, 2'b11));
      word_a = $urandom;
      word_b = $urandom;
      add_row(OP_WRITE, 16'h0010, word_a, 4'hF, '0);   // Swapped into boot RAM
      add_row(OP_WRITE, 16'hC020, word_b, 4'hF, '0);   // Swapped into main RAM
      add_row(OP_WRITE, set_adr(SR_MISC + SR_BLDR_DONE), 32'h1, 4'hF, '0);
      add_row(OP_IDLE, '0, 32'd3, '0, '0);               // Handover reset pulse
      add_row(OP_READ, 16'hC010, '0, 4'hF, word_a);
      add_row(OP_READ, 16'h0020, '0, 4'hF, word_b);
      add_row(OP_READ, set_adr(SR_MISC + SR_BLDR_DONE), '0, 4'hF, 32'h0);
      add_row(OP_PORTS, '0, '0, '0, port_word(8'h00, 2'b00, 1'b1, 2'b11));
      // Byte lane 1 only, then the alias 4 KB up
      word_c = $urandom;
      word_d = $urandom;
      merged = {word_c[31:16], word_d[15:8], word_c[7:0]};
      add_row(OP_WRITE, 16'h0100, word_c, 4'hF, '0);
      add_row(OP_WRITE, 16'h0100, word_d, 4'b0010, '0);
      add_row(OP_READ, 16'h0100, '0, 4'hF, merged);
      add_row(OP_READ, 16'h1100, '0, 4'hF, merged);
      for (int r = 0; r < 2; r++) begin
         run_r    = 4'($urandom);
         led_sw   = 8'($urandom);
         led_src  = 8'($urandom);
         clk_outs = $urandom;
         phy_rst  = $urandom;
         div0     = $urandom;
         div1     = $urandom;
         led_hw_r = 8'(run_r) << 1;   // Run flags sit on LEDs 4:1
         for (int b = 0; b < 8; b++) begin
            led_exp[b] = led_src[b] ? led_hw_r[b] : led_sw[b];
         end
         add_row(OP_INPUTS, '0, {1'b0, 24'h0, run_r, 3'b000}, '0, '0);
         add_row(OP_WRITE, set_adr(SR_MISC + SR_LEDS_SW), {24'h0, led_sw}, 4'hF, '0);
         add_row(OP_WRITE, set_adr(SR_MISC + SR_LED_SRC), {24'h0, led_src}, 4'hF, '0);
         add_row(OP_WRITE, set_adr(SR_MISC + SR_CLK_OUTS), clk_outs, 4'hF, '0);
         add_row(OP_WRITE, set_adr(SR_MISC + SR_PHY_RESET), phy_rst, 4'hF, '0);
         add_row(OP_WRITE, set_adr(SR_DIVSW), div0, 4'hF, '0);
         add_row(OP_WRITE, set_adr(SR_DIVSW + 1), div1, 4'hF, '0);
         add_row(OP_PORTS, '0, '0, '0,
                 port_word(led_exp, clk_outs[6:5], ~phy_rst[0], {div1[0], div0[0]}));
      end
      for (int r = 0; r < 2; r++) begin
         adc_i_r = 12'($urandom);
         adc_q_r = 12'($urandom);
         btn_r   = 1'($urandom);
         aux_r   = 2'($urandom);
         status_exp = (32'(aux_r[1]) << 15) | (32'(aux_r[0]) << 14) | (32'(btn_r) << 13);
         add_row(OP_INPUTS, '0, {1'b0, adc_i_r, adc_q_r, run_r, btn_r, aux_r}, '0, '0);
         add_row(OP_READ, rb_adr(6), '0, 4'hF, {adc_i_r, 4'b0, adc_q_r, 4'b0});
         add_row(OP_READ, rb_adr(12), '0, 4'hF, 32'h0008_0002);
         add_row(OP_READ, rb_adr(13), '0, 4'hF, status_exp);
         add_row(OP_READ, rb_adr(0), '0, 4'hF, 32'h0);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Row execution and checks
   task automatic apply_row(input int idx, input op_row_t row);
      logic [31:0] rd;
      logic [31:0] actual;
      logic        acked;
      case (row.kind)
         OP_WRITE: wb_write(row.adr, row.dat, row.sel);
         OP_READ: begin
            wb_read(row.adr, rd, acked);
            check_count++;
            if (acked && rd !== row.expected) begin
               $display("[FAIL] %0t: row %0d read 0x%h returned 0x%h, expected 0x%h",
                        $time, idx, row.adr, rd, row.expected);
               mismatch_count++;
            end
         end
         OP_INPUTS: begin
            @(posedge wb_clk);
            {adc_i, adc_q, run, button, aux_ld} <= row.dat[30:0];
         end
         OP_PORTS: begin
            @(negedge wb_clk);
            actual = port_word(leds, lms_res, phy_resetn, div_sw);
            check_count++;
            if (actual !== row.expected) begin
               $display("[FAIL] %0t: row %0d ports 0x%h (leds %h), expected 0x%h",
                        $time, idx, actual, leds, row.expected);
               mismatch_count++;
            end
         end
         OP_IDLE: repeat (row.dat) @(posedge wb_clk);
         default: ;
      endcase
   endtask

   initial begin
      void'($urandom(32'hda9f3b18));
      por_rst        = 1'b1;
      wb_req         = '0;
      adc_i          = '0;
      adc_q          = '0;
      run            = '0;
      button         = 1'b0;
      aux_ld         = '0;
      check_count    = 0;
      mismatch_count = 0;
      timeout_count  = 0;
      build_table();
      repeat (16) @(posedge wb_clk);
      por_rst <= 1'b0;
      repeat (2) @(posedge wb_clk);
      foreach (op_table[i]) apply_row(i, op_table[i]);
      $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
               check_count, mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+tests
logic/core_pkg.sv
logic/boot_control.sv
logic/wb_decoder.sv
logic/wb_ram.sv
logic/misc_settings.sv
logic/readback_mux.sv
logic/radio_core.sv
tests/tb_radio_core.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the radio core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f verilog.f --top-module tb_radio_core -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi
out=$(./obj_dir/Vtb_radio_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if printf '%s\n' "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1
